/* all.f */
logic/cvxif_pkg.sv
logic/copro_instr_pkg.sv
logic/instr_decoder.sv
logic/issue_queue.sv
logic/delay_counter.sv
logic/copro_ctrl.sv
logic/result_unit.sv
logic/cvxif_coprocessor.sv
sim/copro_assertions.sv
sim/tb_cvxif_coprocessor.sv

/* logic/copro_ctrl.sv */
// --------------------
// Coprocessor controller
// Sequences commit or kill of the queue head, the
// result delay and the result handshake
// --------------------

`timescale 1ns/1ns

module copro_ctrl (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            clear_i,
  input  logic            empty_i,
  input  cvxif_pkg::id_t  head_id_i,
  input  logic            commit_valid_i,
  input  cvxif_pkg::id_t  commit_id_i,
  input  logic            commit_kill_i,
  input  logic            done_i,
  input  logic            result_ready_i,
  output logic            pop_o,
  output logic            cnt_clear_o,
  output logic            cnt_en_o,
  output logic            load_o,
  output logic            result_valid_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_COMMIT,
    DELAY,
    RESULT
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   waiting;
  logic   commit_hit;
  logic   result_fire;

  // A head that just arrived in IDLE may be committed right away
  assign waiting     = (state_q == IDLE || state_q == WAIT_COMMIT) && !empty_i;
  assign commit_hit  = waiting && commit_valid_i && (commit_id_i == head_id_i);
  assign result_fire = (state_q == RESULT) && result_ready_i;

  assign pop_o          = (commit_hit && commit_kill_i) || result_fire;
  assign cnt_clear_o    = commit_hit && !commit_kill_i;
  assign cnt_en_o       = (state_q == DELAY);
  assign load_o         = (state_q == DELAY) && done_i;
  assign result_valid_o = (state_q == RESULT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, WAIT_COMMIT: begin
        if (empty_i) begin
          state_d = IDLE;
        end else if (commit_hit && !commit_kill_i) begin
          state_d = DELAY;
        end else begin
          // Killed head is popped, the next one is waited on
          state_d = WAIT_COMMIT;
        end
      end
      DELAY: begin
        if (done_i) begin
          state_d = RESULT;
        end
      end
      RESULT: begin
        if (result_fire) begin
          state_d = empty_i ? IDLE : WAIT_COMMIT;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* logic/copro_instr_pkg.sv */
// --------------------
// Custom instruction set
// Opcode and funct3 encodings of the add instructions
// and the internal operation code
// --------------------

package copro_instr_pkg;

  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // Internal operation code carried through the queue
  typedef logic [1:0] op_t;

  // RISC-V custom-0 and custom-1 major opcodes
  localparam opcode_t OPCODE_CUSTOM0 = 7'b000_1011;
  localparam opcode_t OPCODE_CUSTOM1 = 7'b010_1011;

  localparam funct3_t FUNCT3_ADD = 3'b000;
  localparam funct3_t FUNCT3_NOP = 3'b001;

  // Completes with zero and no writeback
  localparam op_t OP_NOP  = 2'd0;
  // rd = rs1 + rs2
  localparam op_t OP_ADD2 = 2'd1;
  // rd = rs1 + rs2 + rs3
  localparam op_t OP_ADD3 = 2'd2;

  // Instruction field positions
  localparam int unsigned OPCODE_LSB = 0;
  localparam int unsigned FUNCT3_LSB = 12;

endpackage

/* logic/cvxif_coprocessor.sv */
// --------------------
// Add coprocessor top level
// Decodes custom adds from the issue channel, queues them
// until commit and returns the delayed sum as a result
// --------------------

`timescale 1ns/1ns

module cvxif_coprocessor #(
  parameter int unsigned QUEUE_DEPTH = 4,
  parameter int unsigned DELAY_BITS  = 3,
  parameter int unsigned NUM_RS      = 3
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  clear_i,
  input  logic                  issue_valid_i,
  input  cvxif_pkg::instr_t     issue_instr_i,
  input  cvxif_pkg::id_t        issue_id_i,
  input  cvxif_pkg::xlen_t      issue_rs1_i,
  input  cvxif_pkg::xlen_t      issue_rs2_i,
  input  cvxif_pkg::xlen_t      issue_rs3_i,
  output logic                  issue_ready_o,
  output logic                  issue_accept_o,
  output logic                  issue_writeback_o,
  input  logic                  commit_valid_i,
  input  cvxif_pkg::id_t        commit_id_i,
  input  logic                  commit_kill_i,
  output logic                  result_valid_o,
  input  logic                  result_ready_i,
  output cvxif_pkg::xlen_t      result_data_o,
  output cvxif_pkg::id_t        result_id_o,
  output cvxif_pkg::reg_addr_t  result_rd_o,
  output logic                  result_we_o
);

  import cvxif_pkg::*;
  import copro_instr_pkg::*;

  op_t                   dec_op;
  logic                  push;
  logic                  pop;
  logic                  full;
  logic                  empty;
  op_t                   head_op;
  id_t                   head_id;
  reg_addr_t             head_rd;
  xlen_t                 head_rs1;
  xlen_t                 head_rs2;
  xlen_t                 head_rs3;
  logic                  head_we;
  logic                  cnt_clear;
  logic                  cnt_en;
  logic                  cnt_done;
  logic                  load;
  logic [DELAY_BITS-1:0] target;

  instr_decoder #(
    .NUM_RS(NUM_RS)
  ) u_decoder (
    .issue_instr_i(issue_instr_i),
    .accept_o     (issue_accept_o),
    .writeback_o  (issue_writeback_o),
    .op_o         (dec_op)
  );

  // Rejected transfers are dropped
  assign push          = issue_valid_i && issue_ready_o && issue_accept_o;
  assign issue_ready_o = !full;

  issue_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_queue (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .flush_i   (clear_i),
    .push_i    (push),
    .pop_i     (pop),
    .in_op_i   (dec_op),
    .in_id_i   (issue_id_i),
    .in_rd_i   (issue_instr_i[11:7]),
    .in_rs1_i  (issue_rs1_i),
    .in_rs2_i  (issue_rs2_i),
    .in_rs3_i  (issue_rs3_i),
    .in_we_i   (issue_writeback_o),
    .head_op_o (head_op),
    .head_id_o (head_id),
    .head_rd_o (head_rd),
    .head_rs1_o(head_rs1),
    .head_rs2_o(head_rs2),
    .head_rs3_o(head_rs3),
    .head_we_o (head_we),
    .full_o    (full),
    .empty_o   (empty)
  );

  copro_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .clear_i       (clear_i),
    .empty_i       (empty),
    .head_id_i     (head_id),
    .commit_valid_i(commit_valid_i),
    .commit_id_i   (commit_id_i),
    .commit_kill_i (commit_kill_i),
    .done_i        (cnt_done),
    .result_ready_i(result_ready_i),
    .pop_o         (pop),
    .cnt_clear_o   (cnt_clear),
    .cnt_en_o      (cnt_en),
    .load_o        (load),
    .result_valid_o(result_valid_o)
  );

  delay_counter #(
    .DELAY_BITS(DELAY_BITS)
  ) u_counter (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .clear_i (cnt_clear),
    .en_i    (cnt_en),
    .target_i(target),
    .done_o  (cnt_done)
  );

  result_unit #(
    .DELAY_BITS(DELAY_BITS)
  ) u_result (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .load_i       (load),
    .op_i         (head_op),
    .id_i         (head_id),
    .rd_i         (head_rd),
    .rs1_i        (head_rs1),
    .rs2_i        (head_rs2),
    .rs3_i        (head_rs3),
    .we_i         (head_we),
    .target_o     (target),
    .result_data_o(result_data_o),
    .result_id_o  (result_id_o),
    .result_rd_o  (result_rd_o),
    .result_we_o  (result_we_o)
  );

endmodule

/* logic/cvxif_pkg.sv */
// --------------------
// Core-side interface types
// Widths and vector types shared by the issue,
// commit and result channels of the coprocessor
// --------------------

package cvxif_pkg;

  // Register width of the host core
  localparam int unsigned XLEN = 32;

  // Instruction word width
  localparam int unsigned ILEN = 32;

  // Width of the id tag the core attaches to each instruction
  localparam int unsigned ID_WIDTH = 4;

  // Architectural register index width
  localparam int unsigned REG_ADDR_WIDTH = 5;

  typedef logic [XLEN-1:0]           xlen_t;
  typedef logic [ILEN-1:0]           instr_t;
  typedef logic [ID_WIDTH-1:0]       id_t;
  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

endpackage

/* logic/delay_counter.sv */
// --------------------
// Delay counter
// Counts cycles after a commit and flags when the
// count reaches the requested target
// --------------------

`timescale 1ns/1ns

module delay_counter #(
  parameter int unsigned DELAY_BITS = 3
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  clear_i,
  input  logic                  en_i,
  input  logic [DELAY_BITS-1:0] target_i,
  output logic                  done_o
);

  logic [DELAY_BITS-1:0] count;

  // Clear wins over counting
  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      count <= '0;
    end else if (en_i) begin
      count <= count + 1'b1;
    end
  end

  assign done_o = (count == target_i);

endmodule

/* logic/instr_decoder.sv */
// --------------------
// Instruction decoder
// Matches an offered word against the custom table and
// returns accept, writeback and the operation code
// --------------------

`timescale 1ns/1ns

module instr_decoder #(
  parameter int unsigned NUM_RS = 3
) (
  input  cvxif_pkg::instr_t     issue_instr_i,
  output logic                  accept_o,
  output logic                  writeback_o,
  output copro_instr_pkg::op_t  op_o
);

  import copro_instr_pkg::*;

  opcode_t opcode;
  funct3_t funct3;

  assign opcode = issue_instr_i[OPCODE_LSB +: 7];
  assign funct3 = issue_instr_i[FUNCT3_LSB +: 3];

  always_comb begin
    // Rejected unless a table entry matches
    accept_o    = 1'b0;
    writeback_o = 1'b0;
    op_o        = OP_NOP;

    case (opcode)
      OPCODE_CUSTOM0: begin
        if (funct3 == FUNCT3_ADD) begin
          accept_o    = 1'b1;
          writeback_o = 1'b1;
          op_o        = OP_ADD2;
        end else if (funct3 == FUNCT3_NOP) begin
          accept_o = 1'b1;
          op_o     = OP_NOP;
        end
      end
      OPCODE_CUSTOM1: begin
        // Three-operand add needs rs3 from the core
        if (funct3 == FUNCT3_ADD && NUM_RS == 3) begin
          accept_o    = 1'b1;
          writeback_o = 1'b1;
          op_o        = OP_ADD3;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

/* logic/issue_queue.sv */
// --------------------
// Issue queue
// In-order circular buffer of accepted instructions,
// head shown fall-through, flushable
// --------------------

`timescale 1ns/1ns

module issue_queue #(
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   flush_i,
  input  logic                   push_i,
  input  logic                   pop_i,
  input  copro_instr_pkg::op_t   in_op_i,
  input  cvxif_pkg::id_t         in_id_i,
  input  cvxif_pkg::reg_addr_t   in_rd_i,
  input  cvxif_pkg::xlen_t       in_rs1_i,
  input  cvxif_pkg::xlen_t       in_rs2_i,
  input  cvxif_pkg::xlen_t       in_rs3_i,
  input  logic                   in_we_i,
  output copro_instr_pkg::op_t   head_op_o,
  output cvxif_pkg::id_t         head_id_o,
  output cvxif_pkg::reg_addr_t   head_rd_o,
  output cvxif_pkg::xlen_t       head_rs1_o,
  output cvxif_pkg::xlen_t       head_rs2_o,
  output cvxif_pkg::xlen_t       head_rs3_o,
  output logic                   head_we_o,
  output logic                   full_o,
  output logic                   empty_o
);

  import cvxif_pkg::*;
  import copro_instr_pkg::*;

  localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

  op_t       op_mem  [QUEUE_DEPTH];
  id_t       id_mem  [QUEUE_DEPTH];
  reg_addr_t rd_mem  [QUEUE_DEPTH];
  xlen_t     rs1_mem [QUEUE_DEPTH];
  xlen_t     rs2_mem [QUEUE_DEPTH];
  xlen_t     rs3_mem [QUEUE_DEPTH];
  logic      we_mem  [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count == CNT_W'(QUEUE_DEPTH));
  assign empty_o = (count == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Pointers and occupancy
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      op_mem[wr_ptr]  <= in_op_i;
      id_mem[wr_ptr]  <= in_id_i;
      rd_mem[wr_ptr]  <= in_rd_i;
      rs1_mem[wr_ptr] <= in_rs1_i;
      rs2_mem[wr_ptr] <= in_rs2_i;
      rs3_mem[wr_ptr] <= in_rs3_i;
      we_mem[wr_ptr]  <= in_we_i;
    end
  end

  assign head_op_o  = op_mem[rd_ptr];
  assign head_id_o  = id_mem[rd_ptr];
  assign head_rd_o  = rd_mem[rd_ptr];
  assign head_rs1_o = rs1_mem[rd_ptr];
  assign head_rs2_o = rs2_mem[rd_ptr];
  assign head_rs3_o = rs3_mem[rd_ptr];
  assign head_we_o  = we_mem[rd_ptr];

endmodule

/* logic/result_unit.sv */
// --------------------
// Result unit
// Adds the head operands, derives the delay target
// and holds the result registers
// --------------------

`timescale 1ns/1ns

module result_unit #(
  parameter int unsigned DELAY_BITS = 3
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   load_i,
  input  copro_instr_pkg::op_t   op_i,
  input  cvxif_pkg::id_t         id_i,
  input  cvxif_pkg::reg_addr_t   rd_i,
  input  cvxif_pkg::xlen_t       rs1_i,
  input  cvxif_pkg::xlen_t       rs2_i,
  input  cvxif_pkg::xlen_t       rs3_i,
  input  logic                   we_i,
  output logic [DELAY_BITS-1:0]  target_o,
  output cvxif_pkg::xlen_t       result_data_o,
  output cvxif_pkg::id_t         result_id_o,
  output cvxif_pkg::reg_addr_t   result_rd_o,
  output logic                   result_we_o
);

  import cvxif_pkg::*;
  import copro_instr_pkg::*;

  xlen_t sum;

  always_comb begin
    case (op_i)
      OP_ADD2: sum = rs1_i + rs2_i;
      OP_ADD3: sum = rs1_i + rs2_i + rs3_i;
      default: sum = '0;
    endcase
  end

  // Low sum bits set how long the result is held back
  assign target_o = sum[DELAY_BITS-1:0];

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      result_data_o <= sum;
      result_id_o   <= id_i;
      result_rd_o   <= rd_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_we_o <= 1'b0;
    end else if (load_i) begin
      result_we_o <= we_i;
    end
  end

endmodule

/* sim/copro_assertions.sv */
// --------------------
// Coprocessor handshake assertions
// Bound into the top level to watch the result
// and issue channels
// --------------------

`timescale 1ns/1ns

module copro_assertions (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 clear_i,
  input logic                 empty_i,
  input logic                 issue_ready_i,
  input logic                 result_valid_i,
  input logic                 result_ready_i,
  input cvxif_pkg::xlen_t     result_data_i,
  input cvxif_pkg::id_t       result_id_i,
  input cvxif_pkg::reg_addr_t result_rd_i,
  input logic                 result_we_i
);

  // A result that is not taken holds all of its fields
  result_stable_a: assert property (@(posedge clk_i) disable iff (rst_i || clear_i)
    result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_data_i) &&
      $stable(result_id_i) && $stable(result_rd_i) && $stable(result_we_i))
  else $error("Result outputs changed under back-pressure");

  no_result_after_flush_a: assert property (@(posedge clk_i)
    (rst_i || clear_i) |=> !result_valid_i)
  else $error("Result valid high right after reset or clear");

  // Flushed queue is empty and takes new instructions
  ready_after_flush_a: assert property (@(posedge clk_i)
    (rst_i || clear_i) |=> empty_i && issue_ready_i)
  else $error("Issue queue not empty and ready right after reset or clear");

endmodule

bind cvxif_coprocessor copro_assertions u_assertions (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .clear_i       (clear_i),
  .empty_i       (empty),
  .issue_ready_i (issue_ready_o),
  .result_valid_i(result_valid_o),
  .result_ready_i(result_ready_i),
  .result_data_i (result_data_o),
  .result_id_i   (result_id_o),
  .result_rd_i   (result_rd_o),
  .result_we_i   (result_we_o)
);

/* sim/tb_cvxif_coprocessor.sv */
// --------------------
// Coprocessor testbench
// Random issue, commit, kill, clear and back-pressure
// traffic checked against a queue model
// --------------------

`timescale 1ns/1ns

module tb_cvxif_coprocessor;

  import cvxif_pkg::*;
  import copro_instr_pkg::*;

  localparam int unsigned QUEUE_DEPTH    = 4;
  localparam int unsigned DELAY_BITS     = 3;
  localparam int unsigned NUM_RS         = 3;
  localparam int unsigned NUM_INSTR      = 300;
  localparam int unsigned TIMEOUT_CYCLES = NUM_INSTR * (2 ** DELAY_BITS + 20);

  // Expected result of one accepted instruction
  typedef struct packed {
    xlen_t     sum;
    id_t       id;
    reg_addr_t rd;
    logic      we;
  } entry_t;

  logic      clk_i;
  logic      rst_i;
  logic      clear_i;
  logic      issue_valid_i;
  instr_t    issue_instr_i;
  id_t       issue_id_i;
  xlen_t     issue_rs1_i;
  xlen_t     issue_rs2_i;
  xlen_t     issue_rs3_i;
  logic      issue_ready_o;
  logic      issue_accept_o;
  logic      issue_writeback_o;
  logic      commit_valid_i;
  id_t       commit_id_i;
  logic      commit_kill_i;
  logic      result_valid_o;
  logic      result_ready_i;
  xlen_t     result_data_o;
  id_t       result_id_o;
  reg_addr_t result_rd_o;
  logic      result_we_o;

  entry_t      model_q[$];
  entry_t      offer;
  logic        offer_accept;
  logic        offer_pending;
  logic        head_committed;
  logic [15:0] lfsr;
  int unsigned cycle_count;
  int unsigned issued;
  int unsigned wait_cnt;
  int unsigned full_seen;
  int unsigned error_count;

  cvxif_coprocessor #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .DELAY_BITS (DELAY_BITS),
    .NUM_RS     (NUM_RS)
  ) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      error_count++;
      $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // New instruction of a random kind with its expected outcome
  task automatic make_offer();
    instr_t     word;
    opcode_t    opc;
    funct3_t    f3;
    logic [1:0] kind;
    logic [1:0] sel;
    word        = rand_bits(32);
    issue_rs1_i = rand_bits(32);
    issue_rs2_i = rand_bits(32);
    issue_rs3_i = rand_bits(32);
    kind        = rand_bits(2);
    sel         = rand_bits(2);
    f3          = rand_bits(3);
    opc         = rand_bits(7);
    case (kind)
      2'd0: begin
        opc = OPCODE_CUSTOM0;
        f3  = FUNCT3_ADD;
      end
      2'd1: begin
        opc = OPCODE_CUSTOM1;
        f3  = FUNCT3_ADD;
      end
      2'd2: begin
        opc = OPCODE_CUSTOM0;
        f3  = FUNCT3_NOP;
      end
      default: begin
        if (sel == 2'd0) begin
          opc = OPCODE_CUSTOM0;
          f3  = (f3 < 3'd2) ? f3 + 3'd2 : f3;
        end else if (sel == 2'd1) begin
          opc = OPCODE_CUSTOM1;
          f3  = (f3 == 3'd0) ? 3'd1 : f3;
        end else if (opc == OPCODE_CUSTOM0 || opc == OPCODE_CUSTOM1) begin
          // Bit 6 set leaves neither custom opcode
          opc[6] = 1'b1;
        end
      end
    endcase
    word[6:0]    = opc;
    word[14:12]  = f3;
    offer.id     = id_t'(issued);
    offer.rd     = word[11:7];
    offer.we     = (kind == 2'd0) || (kind == 2'd1 && NUM_RS == 3);
    offer_accept = (kind != 2'd3) && (kind != 2'd1 || NUM_RS == 3);
    case (kind)
      2'd0:    offer.sum = issue_rs1_i + issue_rs2_i;
      2'd1:    offer.sum = issue_rs1_i + issue_rs2_i + issue_rs3_i;
      default: offer.sum = '0;
    endcase
    issue_instr_i = word;
    issue_id_i    = offer.id;
    offer_pending = 1'b1;
  endtask

  // Check outputs at the falling edge, then drive the next cycle
  task automatic step_cycle();
    entry_t head;
    logic   exp_valid;
    logic   ready_now;
    logic   commit_hit;
    logic   hold;
    if (head_committed) begin
      wait_cnt++;
    end
    head      = (model_q.size() > 0) ? model_q[0] : '0;
    ready_now = (model_q.size() < QUEUE_DEPTH);
    exp_valid = head_committed && (wait_cnt >= head.sum[DELAY_BITS-1:0] + 2);
    hold      = (issued < NUM_INSTR) && (((cycle_count >> 6) % 4) == 0);
    if (!ready_now) begin
      full_seen++;
    end
    check_value(issue_ready_o, ready_now, "issue_ready_o");
    check_value(result_valid_o, exp_valid, "result_valid_o");
    if (exp_valid) begin
      check_value(result_data_o, head.sum, "result_data_o");
      check_value(result_id_o, head.id, "result_id_o");
      check_value(result_rd_o, head.rd, "result_rd_o");
      check_value(result_we_o, head.we, "result_we_o");
    end

    if (issued < NUM_INSTR && rand_bits(8) == 0) begin
      // Flush all work in flight
      clear_i        = 1'b1;
      issue_valid_i  = 1'b0;
      commit_valid_i = 1'b0;
      result_ready_i = 1'b0;
      model_q.delete();
      head_committed = 1'b0;
      offer_pending  = 1'b0;
    end else begin
      clear_i        = 1'b0;
      result_ready_i = rand_bits(1);
      commit_valid_i = 1'b0;
      commit_kill_i  = rand_bits(1);
      commit_id_i    = rand_bits(4);
      commit_hit     = 1'b0;
      if (model_q.size() > 0 && !head_committed && !hold) begin
        if (rand_bits(1)) begin
          commit_valid_i = 1'b1;
          commit_id_i    = head.id;
          commit_kill_i  = (rand_bits(2) == 0);
          commit_hit     = 1'b1;
        end else if (rand_bits(2) == 0) begin
          // Commit for another id is ignored
          commit_valid_i = 1'b1;
          commit_id_i    = head.id + 1'b1;
        end
      end
      if (!offer_pending && issued < NUM_INSTR && rand_bits(2) != 0) begin
        make_offer();
      end
      issue_valid_i = offer_pending;
      #1;
      if (offer_pending) begin
        check_value(issue_accept_o, offer_accept, "issue_accept_o");
        check_value(issue_writeback_o, offer.we, "issue_writeback_o");
      end

      // Model follows the coming rising edge
      if (exp_valid && result_ready_i) begin
        model_q.delete(0);
        head_committed = 1'b0;
      end
      if (commit_hit && commit_kill_i) begin
        model_q.delete(0);
      end else if (commit_hit) begin
        head_committed = 1'b1;
        wait_cnt       = 0;
      end
      if (offer_pending && ready_now) begin
        offer_pending = 1'b0;
        issued++;
        if (offer_accept) begin
          model_q.push_back(offer);
        end
      end
    end
  endtask

  initial begin
    lfsr           = 16'd76;
    cycle_count    = 0;
    issued         = 0;
    wait_cnt       = 0;
    full_seen      = 0;
    error_count    = 0;
    offer          = '0;
    offer_accept   = 1'b0;
    offer_pending  = 1'b0;
    head_committed = 1'b0;
    rst_i          = 1'b1;
    clear_i        = 1'b0;
    issue_valid_i  = 1'b0;
    issue_instr_i  = '0;
    issue_id_i     = '0;
    issue_rs1_i    = '0;
    issue_rs2_i    = '0;
    issue_rs3_i    = '0;
    commit_valid_i = 1'b0;
    commit_id_i    = '0;
    commit_kill_i  = 1'b0;
    result_ready_i = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    while (issued < NUM_INSTR || offer_pending || model_q.size() > 0) begin
      step_cycle();
      @(negedge clk_i);
    end
    // A few idle cycles, no stray result may show up
    repeat (4) begin
      step_cycle();
      @(negedge clk_i);
    end
    if (full_seen == 0) begin
      error_count++;
      $display("The issue queue never filled up during the run");
    end
    if (error_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("RESULT: FAIL");
      $fatal(1, "Run ended with errors");
    end
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $fatal(1, "Timeout");
  end

endmodule
